// File: logic/cart_pkg.sv
`default_nettype none

package cart_pkg;

  localparam int snes_addr_w = 24;
  localparam int snes_data_w = 8;

  typedef logic [snes_addr_w-1:0] snes_addr_t;
  typedef logic [snes_data_w-1:0] snes_byte_t;

  typedef enum logic [1:0] {
    region_none    = 2'd0,
    region_rom     = 2'd1,
    region_saveram = 2'd2,
    region_snescmd = 2'd3
  } region_t;

  localparam logic [15:0] snescmd_base = 16'h2A00; // 16 bytes, banks 00-3F / 80-BF
  localparam logic [7:0] saveram_bank_lo = 8'h70;
  localparam logic [7:0] saveram_bank_hi = 8'h7D;
  localparam snes_addr_t saveram_base = 24'hE00000; // Top of PSRAM
  localparam int strobe_hist_w = 8;

endpackage

`default_nettype wire

// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int rom_addr_w = 23; // 16-bit words
  localparam int rom_data_w = 16;

  // One-hot arbiter states
  typedef enum logic [11:0] {
    idle          = 12'b0000_0000_0001,
    snes_rd_end   = 12'b0000_0000_0010,
    snes_wr_addr  = 12'b0000_0000_0100,
    snes_wr_wait1 = 12'b0000_0000_1000,
    snes_wr_wait2 = 12'b0000_0001_0000,
    snes_wr_end   = 12'b0000_0010_0000,
    mcu_rd_addr   = 12'b0000_0100_0000,
    mcu_rd_wait   = 12'b0000_1000_0000,
    mcu_rd_end    = 12'b0001_0000_0000,
    mcu_wr_addr   = 12'b0010_0000_0000,
    mcu_wr_wait   = 12'b0100_0000_0000,
    mcu_wr_end    = 12'b1000_0000_0000
  } mem_state_t;

  typedef logic [3:0] wait_cnt_t;

  localparam wait_cnt_t rom_wr_wait1 = 4'd2;
  localparam wait_cnt_t rom_wr_wait2 = 4'd1;
  localparam wait_cnt_t rom_rd_wait_mcu = 4'd6;
  localparam wait_cnt_t rom_wr_wait_mcu = 4'd5;

  localparam logic [16:0] snes_dead_timeout = 17'd88000; // About 1 ms of CLK2

endpackage

`default_nettype wire

// File: logic/snes_bus_sync.sv
`default_nettype none

module snes_bus_sync (
  input  logic                 clk2,
  input  logic                 rst_n,
  input  cart_pkg::snes_addr_t snes_addr_in,
  input  logic                 snes_read,
  input  logic                 snes_write,
  input  logic                 snes_cpu_clk,
  output cart_pkg::snes_addr_t snes_addr,
  output logic                 cycle_start,
  output logic                 cycle_end,
  output logic                 wr_end,
  output logic                 read_q,
  output logic                 snes_dead
);

  cart_pkg::snes_addr_t addr_q [3];
  logic [cart_pkg::strobe_hist_w-1:0] read_hist;
  logic [cart_pkg::strobe_hist_w-1:0] write_hist;
  logic [cart_pkg::strobe_hist_w-1:0] clk_hist;
  logic [cart_pkg::strobe_hist_w-3:0] clk_stable; // Two-sample agreement
  logic [$bits(mem_pkg::snes_dead_timeout)-1:0] dead_cnt;

  always_ff @(posedge clk2) begin
    addr_q[0] <= snes_addr_in;
    addr_q[1] <= addr_q[0];
    addr_q[2] <= addr_q[1];
  end

  assign snes_addr = addr_q[2] & addr_q[1]; // Filters single-sample glitches

  ////////////////////
  // Strobe history, newest sample in bit 0
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      read_hist  <= '1;
      write_hist <= '1;
      clk_hist   <= '0;
    end else begin
      read_hist  <= {read_hist[cart_pkg::strobe_hist_w-2:0], snes_read};
      write_hist <= {write_hist[cart_pkg::strobe_hist_w-2:0], snes_write};
      clk_hist   <= {clk_hist[cart_pkg::strobe_hist_w-2:0], snes_cpu_clk};
    end
  end

  assign clk_stable = clk_hist[cart_pkg::strobe_hist_w-1:2] & clk_hist[cart_pkg::strobe_hist_w-2:1];
  assign cycle_start = clk_stable[0] && !(|clk_stable[cart_pkg::strobe_hist_w-3:1]);
  assign cycle_end = !clk_stable[0] && (&clk_stable[cart_pkg::strobe_hist_w-3:1]);
  assign wr_end = write_hist[1] && !(|write_hist[cart_pkg::strobe_hist_w-1:2]); // /WR rise
  assign read_q = read_hist[0];

  ////////////////////
  // Dead console detection
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b0;
    end else begin
      if (clk_hist[0]) dead_cnt <= '0;
      else if (dead_cnt <= mem_pkg::snes_dead_timeout) dead_cnt <= dead_cnt + 1'b1; // Saturates
      if (dead_cnt > mem_pkg::snes_dead_timeout) snes_dead <= 1'b1;
      else if (clk_hist[0]) snes_dead <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: logic/cart_map.sv
`default_nettype none

module cart_map (
  input  cart_pkg::snes_addr_t snes_addr,
  input  cart_pkg::snes_addr_t rom_mask,
  input  cart_pkg::snes_addr_t saveram_mask,
  output cart_pkg::region_t    region,
  output cart_pkg::snes_addr_t mapped_addr
);

  logic [7:0] bank;
  logic       is_snescmd;
  logic       is_saveram;

  assign bank = snes_addr[23:16];

  // Window only in system banks, bit 22 clear
  assign is_snescmd = !snes_addr[22]
                      && (snes_addr[15:4] == cart_pkg::snescmd_base[15:4]);
  assign is_saveram = !snes_addr[15]
                      && (bank >= cart_pkg::saveram_bank_lo)
                      && (bank <= cart_pkg::saveram_bank_hi);

  always_comb begin
    region      = cart_pkg::region_none;
    mapped_addr = '0;
    if (is_snescmd) begin
      region = cart_pkg::region_snescmd; // Served from the register window
    end else if (snes_addr[15]) begin
      region      = cart_pkg::region_rom;
      mapped_addr = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask; // LoROM 32K pages
    end else if (is_saveram) begin
      region      = cart_pkg::region_saveram;
      mapped_addr = cart_pkg::saveram_base + (snes_addr & saveram_mask);
    end
  end

endmodule

`default_nettype wire

// File: logic/snescmd_regs.sv
`default_nettype none

module snescmd_regs (
  input  logic                 clk2,
  input  logic                 rst_n,
  input  logic                 wr_en,
  input  logic [3:0]           idx,
  input  cart_pkg::snes_byte_t wdata,
  output cart_pkg::snes_byte_t rdata
);

  cart_pkg::snes_byte_t regs [16];

  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[idx] <= wdata;
    end
  end

  assign rdata = regs[idx]; // Console reads back without a wait

endmodule

`default_nettype wire

// File: logic/rom_arbiter.sv
`default_nettype none

module rom_arbiter (
  input  logic                           clk2,
  input  logic                           rst_n,
  input  logic                           cycle_start,
  input  logic                           cycle_end,
  input  logic                           snes_write,
  input  logic                           snes_cpu_clk,
  input  logic                           snes_dead,
  input  cart_pkg::region_t              region,
  input  cart_pkg::snes_byte_t           snes_data_in,
  input  cart_pkg::snes_addr_t           mcu_addr,
  input  cart_pkg::snes_byte_t           mcu_wdata,
  input  logic                           mcu_rrq,
  input  logic                           mcu_wrq,
  input  logic [mem_pkg::rom_data_w-1:0] rom_rdata,
  input  logic                           addr0,
  output logic                           rom_sa,
  output cart_pkg::snes_addr_t           rom_addr_r,
  output cart_pkg::snes_byte_t           rom_wdata_byte,
  output logic                           rom_wdata_en,
  output logic                           rom_we_r,
  output cart_pkg::snes_byte_t           snes_rdata,
  output cart_pkg::snes_byte_t           mcu_rdata,
  output logic                           mcu_rdy
);

  mem_pkg::mem_state_t  state;
  mem_pkg::wait_cnt_t   wait_cnt;
  logic                 rd_pend;
  logic                 wr_pend;
  logic                 mcu_take;
  cart_pkg::snes_byte_t mcu_wdata_r;
  cart_pkg::snes_byte_t rd_lane;

  assign mcu_take = mcu_rdy && (mcu_rrq || mcu_wrq);
  assign rd_lane = addr0 ? rom_rdata[7:0] : rom_rdata[15:8]; // Odd bytes on low lane

  ////////////////////
  // Data latches
  always_ff @(posedge clk2) begin
    if (mcu_take) begin
      rom_addr_r  <= mcu_addr;
      mcu_wdata_r <= mcu_wdata;
    end
    if (state == mem_pkg::idle && cycle_start && snes_write) snes_rdata <= rd_lane;
    if (state == mem_pkg::mcu_rd_end) mcu_rdata <= rd_lane;
    if (state == mem_pkg::snes_wr_wait1 && (wait_cnt == '0 || cycle_end)) begin
      rom_wdata_byte <= snes_data_in;
    end else if (state == mem_pkg::mcu_wr_addr) begin
      rom_wdata_byte <= mcu_wdata_r;
    end
  end

  ////////////////////
  // Handshake and state machine
  always_ff @(posedge clk2 or negedge rst_n) begin
    if (!rst_n) begin
      state        <= mem_pkg::idle;
      wait_cnt     <= '0;
      rom_sa       <= 1'b1;
      rom_wdata_en <= 1'b0;
      rom_we_r     <= 1'b1;
      mcu_rdy      <= 1'b1;
      rd_pend      <= 1'b0;
      wr_pend      <= 1'b0;
    end else begin
      if (mcu_rdy && mcu_rrq) begin
        rd_pend <= 1'b1;
        mcu_rdy <= 1'b0;
      end else if (mcu_rdy && mcu_wrq) begin
        wr_pend <= 1'b1;
        mcu_rdy <= 1'b0;
      end else if (state == mem_pkg::mcu_rd_end || state == mem_pkg::mcu_wr_end) begin
        rd_pend <= 1'b0;
        wr_pend <= 1'b0;
        mcu_rdy <= 1'b1;
      end

      if (snes_dead && snes_cpu_clk) begin // Console is back, abort and retry later
        state        <= mem_pkg::idle;
        rom_sa       <= 1'b1;
        rom_we_r     <= 1'b1;
        rom_wdata_en <= 1'b0;
      end else begin
        case (state)
          mem_pkg::idle: begin
            rom_wdata_en <= 1'b0;
            if (cycle_start && !snes_write) begin
              state <= mem_pkg::snes_wr_addr;
              if (region == cart_pkg::region_saveram) begin // Only save-RAM is writable
                rom_we_r     <= 1'b0;
                rom_wdata_en <= 1'b1;
              end
            end else if (cycle_start) begin
              state <= mem_pkg::snes_rd_end;
            end else if (snes_dead && rd_pend) begin
              state <= mem_pkg::mcu_rd_addr;
            end else if (snes_dead && wr_pend) begin
              state <= mem_pkg::mcu_wr_addr;
            end
          end
          mem_pkg::snes_rd_end, mem_pkg::snes_wr_end: begin
            rom_wdata_en <= 1'b0;
            if (rd_pend) state <= mem_pkg::mcu_rd_addr;
            else if (wr_pend) state <= mem_pkg::mcu_wr_addr;
            else state <= mem_pkg::idle;
          end
          mem_pkg::snes_wr_addr: begin
            wait_cnt <= mem_pkg::rom_wr_wait1;
            state    <= mem_pkg::snes_wr_wait1;
          end
          mem_pkg::snes_wr_wait1: begin
            wait_cnt <= wait_cnt - 1'b1;
            if (wait_cnt == '0 || cycle_end) begin // Data valid by now
              wait_cnt <= mem_pkg::rom_wr_wait2;
              state    <= mem_pkg::snes_wr_wait2;
            end
          end
          mem_pkg::snes_wr_wait2: begin
            wait_cnt <= wait_cnt - 1'b1;
            if (wait_cnt == '0 || cycle_end) begin
              rom_we_r <= 1'b1;
              state    <= mem_pkg::snes_wr_end;
            end
          end
          mem_pkg::mcu_rd_addr: begin
            rom_sa   <= 1'b0;
            wait_cnt <= mem_pkg::rom_rd_wait_mcu;
            state    <= mem_pkg::mcu_rd_wait;
          end
          mem_pkg::mcu_rd_wait: begin
            wait_cnt <= wait_cnt - 1'b1;
            if (wait_cnt == '0) state <= mem_pkg::mcu_rd_end;
          end
          mem_pkg::mcu_rd_end: begin
            rom_sa <= 1'b1; // Console address back before idle
            state  <= mem_pkg::idle;
          end
          mem_pkg::mcu_wr_addr: begin
            rom_sa       <= 1'b0;
            wait_cnt     <= mem_pkg::rom_wr_wait_mcu;
            rom_wdata_en <= 1'b1;
            rom_we_r     <= 1'b0;
            state        <= mem_pkg::mcu_wr_wait;
          end
          mem_pkg::mcu_wr_wait: begin
            wait_cnt <= wait_cnt - 1'b1;
            if (wait_cnt == '0) begin
              rom_we_r <= 1'b1;
              state    <= mem_pkg::mcu_wr_end;
            end
          end
          mem_pkg::mcu_wr_end: begin
            rom_sa       <= 1'b1;
            rom_wdata_en <= 1'b0;
            state        <= mem_pkg::idle;
          end
          default: state <= mem_pkg::idle;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/psram_port.sv
`default_nettype none

module psram_port (
  input  logic                           rom_sa,
  input  cart_pkg::snes_addr_t           mapped_addr,
  input  cart_pkg::snes_addr_t           rom_addr_r,
  input  cart_pkg::snes_byte_t           rom_wdata_byte,
  input  logic                           rom_wdata_en,
  input  logic                           rom_we_r,
  output logic [mem_pkg::rom_addr_w-1:0] rom_addr,
  output logic [mem_pkg::rom_data_w-1:0] rom_wdata,
  output logic                           rom_wdata_oe,
  output logic                           rom_we,
  output logic                           rom_bhe,
  output logic                           rom_ble,
  output logic                           addr0
);

  cart_pkg::snes_addr_t sel_addr;

  assign sel_addr = rom_sa ? mapped_addr : rom_addr_r; // Console or MCU side

  assign rom_addr = sel_addr[mem_pkg::rom_addr_w:1];
  assign addr0    = sel_addr[0];

  // Byte lane steering, other lane held at zero
  assign rom_wdata = addr0 ? {8'h00, rom_wdata_byte} : {rom_wdata_byte, 8'h00};
  assign rom_wdata_oe = rom_wdata_en;
  assign rom_we = rom_we_r;

  assign rom_bhe = addr0;  // Active low
  assign rom_ble = !addr0;

endmodule

`default_nettype wire

// File: logic/sd2snes_main.sv
`default_nettype none

module sd2snes_main (
  input  logic                           clk2,
  input  logic                           rst_n,
  input  cart_pkg::snes_addr_t           snes_addr_in,
  input  logic                           snes_read,
  input  logic                           snes_write,
  input  logic                           snes_cpu_clk,
  input  cart_pkg::snes_byte_t           snes_data_in,
  output cart_pkg::snes_byte_t           snes_data_out,
  output logic                           snes_data_oe,
  input  cart_pkg::snes_addr_t           mcu_addr,
  input  cart_pkg::snes_byte_t           mcu_wdata,
  input  logic                           mcu_rrq,
  input  logic                           mcu_wrq,
  output cart_pkg::snes_byte_t           mcu_rdata,
  output logic                           mcu_rdy,
  input  logic [mem_pkg::rom_data_w-1:0] rom_rdata,
  output logic [mem_pkg::rom_addr_w-1:0] rom_addr,
  output logic [mem_pkg::rom_data_w-1:0] rom_wdata,
  output logic                           rom_wdata_oe,
  output logic                           rom_we,
  output logic                           rom_bhe,
  output logic                           rom_ble,
  input  cart_pkg::snes_addr_t           rom_mask,
  input  cart_pkg::snes_addr_t           saveram_mask
);

  cart_pkg::snes_addr_t snes_addr;
  cart_pkg::snes_addr_t mapped_addr;
  cart_pkg::snes_addr_t rom_addr_r;
  cart_pkg::region_t    region;
  cart_pkg::snes_byte_t cmd_rdata;
  cart_pkg::snes_byte_t arb_rdata;
  cart_pkg::snes_byte_t rom_wdata_byte;
  logic cycle_start;
  logic cycle_end;
  logic wr_end;
  logic read_q;
  logic snes_dead;
  logic rom_sa;
  logic rom_wdata_en;
  logic rom_we_r;
  logic addr0;

  snes_bus_sync sync_i (
    .clk2(clk2), .rst_n(rst_n), .snes_addr_in(snes_addr_in),
    .snes_read(snes_read), .snes_write(snes_write), .snes_cpu_clk(snes_cpu_clk),
    .snes_addr(snes_addr), .cycle_start(cycle_start), .cycle_end(cycle_end),
    .wr_end(wr_end), .read_q(read_q), .snes_dead(snes_dead)
  );

  cart_map map_i (
    .snes_addr(snes_addr), .rom_mask(rom_mask), .saveram_mask(saveram_mask),
    .region(region), .mapped_addr(mapped_addr)
  );

  snescmd_regs cmd_i (
    .clk2(clk2), .rst_n(rst_n),
    .wr_en(wr_end && region == cart_pkg::region_snescmd), // Written as /WR rises
    .idx(snes_addr[3:0]), .wdata(snes_data_in), .rdata(cmd_rdata)
  );

  rom_arbiter arb_i (
    .clk2(clk2), .rst_n(rst_n), .cycle_start(cycle_start), .cycle_end(cycle_end),
    .snes_write(snes_write), .snes_cpu_clk(snes_cpu_clk), .snes_dead(snes_dead),
    .region(region), .snes_data_in(snes_data_in), .mcu_addr(mcu_addr),
    .mcu_wdata(mcu_wdata), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .rom_rdata(rom_rdata),
    .addr0(addr0), .rom_sa(rom_sa), .rom_addr_r(rom_addr_r),
    .rom_wdata_byte(rom_wdata_byte), .rom_wdata_en(rom_wdata_en), .rom_we_r(rom_we_r),
    .snes_rdata(arb_rdata), .mcu_rdata(mcu_rdata), .mcu_rdy(mcu_rdy)
  );

  psram_port port_i (
    .rom_sa(rom_sa), .mapped_addr(mapped_addr), .rom_addr_r(rom_addr_r),
    .rom_wdata_byte(rom_wdata_byte), .rom_wdata_en(rom_wdata_en), .rom_we_r(rom_we_r),
    .rom_addr(rom_addr), .rom_wdata(rom_wdata), .rom_wdata_oe(rom_wdata_oe),
    .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble), .addr0(addr0)
  );

  // Console read data
  assign snes_data_out = (region == cart_pkg::region_snescmd) ? cmd_rdata : arb_rdata;
  assign snes_data_oe  = !read_q;

endmodule

`default_nettype wire

// File: verif/tb_checker.sv
`default_nettype none

module tb_checker (
  input  logic                 clk2,
  input  logic                 ev_valid,
  input  logic [2:0]           ev_kind,
  input  cart_pkg::snes_addr_t ev_addr,
  input  cart_pkg::snes_byte_t ev_data,
  input  cart_pkg::snes_addr_t rom_mask,
  input  cart_pkg::snes_addr_t saveram_mask,
  input  cart_pkg::snes_byte_t snes_data_out,
  input  logic                 snes_data_oe,
  input  cart_pkg::snes_byte_t mcu_rdata,
  input  logic                 mcu_rdy,
  input  logic                 rom_we,
  input  logic                 rom_wdata_oe,
  input  logic [15:0]          probe_word,
  output logic [22:0]          probe_addr,
  output int                   mismatch_cnt
);

  localparam logic [2:0] k_reset  = 3'd0;
  localparam logic [2:0] k_read   = 3'd1;
  localparam logic [2:0] k_write  = 3'd2;
  localparam logic [2:0] k_mcu_wr = 3'd3;
  localparam logic [2:0] k_mcu_rd = 3'd4;

  cart_pkg::snes_byte_t written [int]; // Mirror of PSRAM bytes touched so far
  cart_pkg::snes_byte_t cmd_mirror [16];

  initial begin
    mismatch_cnt = 0;
    probe_addr   = '0;
    for (int i = 0; i < 16; i++) cmd_mirror[i] = '0;
  end

  ////////////////////
  // Reference model
  function automatic cart_pkg::region_t region_of(input cart_pkg::snes_addr_t a);
    if (!a[22] && a[15:4] == 12'h2A0) return cart_pkg::region_snescmd;
    if (a[15]) return cart_pkg::region_rom;
    if (a[23:16] >= 8'h70 && a[23:16] <= 8'h7D) return cart_pkg::region_saveram;
    return cart_pkg::region_none;
  endfunction

  function automatic cart_pkg::snes_addr_t map_addr(input cart_pkg::snes_addr_t a);
    cart_pkg::snes_addr_t page;
    page = 24'(a[22:16]) * 24'h8000; // 32K bytes per LoROM bank
    if (a[15]) return (page + 24'(a[14:0])) & rom_mask;
    return 24'hE00000 + (a & saveram_mask);
  endfunction

  function automatic cart_pkg::snes_byte_t lane_byte(input logic [15:0] w, input logic odd);
    return odd ? w[7:0] : w[15:8]; // Even byte on the high lane
  endfunction

  function automatic cart_pkg::snes_byte_t pattern_of(input cart_pkg::snes_addr_t a);
    return a[7:0] ^ a[15:8] ^ {a[23], 7'h35};
  endfunction

  function automatic cart_pkg::snes_byte_t mirror_byte(input cart_pkg::snes_addr_t a);
    return written.exists(int'(a)) ? written[int'(a)] : pattern_of(a);
  endfunction

  task automatic report(input string what, input cart_pkg::snes_addr_t a,
                        input cart_pkg::snes_byte_t got, input cart_pkg::snes_byte_t exp);
    if (got !== exp) begin
      mismatch_cnt++;
      $display("mismatch at time %0t: %s at %h, got %h, expected %h", $time, what, a, got, exp);
    end
  endtask

  task automatic check_model(input cart_pkg::snes_addr_t m);
    probe_addr = m[23:1];
    #1;
    report("PSRAM byte", m, lane_byte(probe_word, m[0]), mirror_byte(m));
  endtask

  ////////////////////
  // Comparing process
  always @(posedge clk2) begin : compare
    cart_pkg::region_t    r;
    cart_pkg::snes_byte_t exp;
    if (ev_valid) begin
      r = region_of(ev_addr);
      case (ev_kind)
        k_reset: begin
          if (mcu_rdy !== 1'b1 || rom_we !== 1'b1 || rom_wdata_oe !== 1'b0
              || snes_data_oe !== 1'b0) begin
            mismatch_cnt++;
            $display("mismatch at time %0t: reset state rdy=%b we=%b wd_oe=%b oe=%b",
                     $time, mcu_rdy, rom_we, rom_wdata_oe, snes_data_oe);
          end
        end
        k_read: begin
          if (r == cart_pkg::region_snescmd) exp = cmd_mirror[ev_addr[3:0]];
          else exp = mirror_byte(map_addr(ev_addr));
          if (r != cart_pkg::region_none) report("console read", ev_addr, snes_data_out, exp);
          if (snes_data_oe !== 1'b1) begin
            mismatch_cnt++;
            $display("mismatch at time %0t: data bus not driven during read", $time);
          end
        end
        k_write: begin
          if (r == cart_pkg::region_saveram) written[int'(map_addr(ev_addr))] = ev_data;
          if (r == cart_pkg::region_snescmd) cmd_mirror[ev_addr[3:0]] = ev_data;
          if (r == cart_pkg::region_rom || r == cart_pkg::region_saveram) begin
            check_model(map_addr(ev_addr)); // ROM stays untouched
          end
        end
        k_mcu_wr: begin
          written[int'(ev_addr)] = ev_data;
          check_model(ev_addr);
        end
        k_mcu_rd: report("MCU read", ev_addr, mcu_rdata, mirror_byte(ev_addr));
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_top.sv
`default_nettype none

module tb_top;

  localparam logic [2:0] k_reset  = 3'd0;
  localparam logic [2:0] k_read   = 3'd1;
  localparam logic [2:0] k_write  = 3'd2;
  localparam logic [2:0] k_mcu_wr = 3'd3;
  localparam logic [2:0] k_mcu_rd = 3'd4;
  localparam int cycle_len = 25;      // Console cycle plus event slot
  localparam int console_cycles = 64;
  localparam int mcu_limit = 200;
  localparam longint dead_cycles = longint'(mem_pkg::snes_dead_timeout);
  localparam longint watchdog_limit =
    (longint'(console_cycles * cycle_len + 4 * mcu_limit) + 2 * dead_cycles) * 100;

  logic clk2;
  logic rst_n;
  cart_pkg::snes_addr_t snes_addr_in;
  logic snes_read;
  logic snes_write;
  logic snes_cpu_clk;
  cart_pkg::snes_byte_t snes_data_in;
  cart_pkg::snes_byte_t snes_data_out;
  logic snes_data_oe;
  cart_pkg::snes_addr_t mcu_addr;
  cart_pkg::snes_byte_t mcu_wdata;
  logic mcu_rrq;
  logic mcu_wrq;
  cart_pkg::snes_byte_t mcu_rdata;
  logic mcu_rdy;
  logic [mem_pkg::rom_data_w-1:0] rom_rdata;
  logic [mem_pkg::rom_addr_w-1:0] rom_addr;
  logic [mem_pkg::rom_data_w-1:0] rom_wdata;
  logic rom_wdata_oe;
  logic rom_we;
  logic rom_bhe;
  logic rom_ble;
  cart_pkg::snes_addr_t rom_mask;
  cart_pkg::snes_addr_t saveram_mask;
  logic ev_valid;
  logic [2:0] ev_kind;
  cart_pkg::snes_addr_t ev_addr;
  cart_pkg::snes_byte_t ev_data;
  logic [22:0] probe_addr;
  logic [15:0] probe_word;
  int mismatch_cnt;
  int handshake_errs;
  integer seed;
  logic [7:0] psram [0:131071]; // Bit 23 and low 16 bits of the byte address

  sd2snes_main dut_i (
    .clk2(clk2), .rst_n(rst_n), .snes_addr_in(snes_addr_in), .snes_read(snes_read),
    .snes_write(snes_write), .snes_cpu_clk(snes_cpu_clk), .snes_data_in(snes_data_in),
    .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe), .mcu_addr(mcu_addr),
    .mcu_wdata(mcu_wdata), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_rdata(mcu_rdata),
    .mcu_rdy(mcu_rdy), .rom_rdata(rom_rdata), .rom_addr(rom_addr), .rom_wdata(rom_wdata),
    .rom_wdata_oe(rom_wdata_oe), .rom_we(rom_we), .rom_bhe(rom_bhe), .rom_ble(rom_ble),
    .rom_mask(rom_mask), .saveram_mask(saveram_mask)
  );

  tb_checker checker_i (
    .clk2(clk2), .ev_valid(ev_valid), .ev_kind(ev_kind), .ev_addr(ev_addr),
    .ev_data(ev_data), .rom_mask(rom_mask), .saveram_mask(saveram_mask),
    .snes_data_out(snes_data_out), .snes_data_oe(snes_data_oe), .mcu_rdata(mcu_rdata),
    .mcu_rdy(mcu_rdy), .rom_we(rom_we), .rom_wdata_oe(rom_wdata_oe),
    .probe_word(probe_word), .probe_addr(probe_addr), .mismatch_cnt(mismatch_cnt)
  );

  ////////////////////
  // PSRAM model
  assign rom_rdata = {psram[{rom_addr[22], rom_addr[14:0], 1'b0}],
                      psram[{rom_addr[22], rom_addr[14:0], 1'b1}]};
  assign probe_word = {psram[{probe_addr[22], probe_addr[14:0], 1'b0}],
                       psram[{probe_addr[22], probe_addr[14:0], 1'b1}]};

  always @(posedge rom_we) begin
    if (rst_n && rom_wdata_oe) begin // Data only lands while the bus is driven
      if (!rom_bhe) psram[{rom_addr[22], rom_addr[14:0], 1'b0}] = rom_wdata[15:8];
      if (!rom_ble) psram[{rom_addr[22], rom_addr[14:0], 1'b1}] = rom_wdata[7:0];
    end
  end

  function automatic logic [7:0] fill_byte(input logic [16:0] a);
    return a[7:0] ^ a[15:8] ^ {a[16], 7'h35};
  endfunction

  initial begin
    clk2 = 1'b0;
    forever #50 clk2 = ~clk2;
  end

  initial begin
    #(watchdog_limit);
    $display("Watchdog timeout at %0t, the run did not finish", $time);
    $display("Checks failed");
    $finish;
  end

  ////////////////////
  // Stimulus tasks
  task automatic post_event(input logic [2:0] kind, input cart_pkg::snes_addr_t a,
                            input cart_pkg::snes_byte_t d);
    ev_kind  = kind;
    ev_addr  = a;
    ev_data  = d;
    ev_valid = 1'b1;
    @(negedge clk2);
    ev_valid = 1'b0;
  endtask

  task automatic console_cycle(input cart_pkg::snes_addr_t a, input logic wr,
                               input cart_pkg::snes_byte_t d);
    snes_addr_in = a;
    snes_cpu_clk = 1'b0;
    snes_read    = 1'b1;
    snes_write   = 1'b1;
    repeat (8) @(negedge clk2);
    snes_cpu_clk = 1'b1;
    if (wr) begin
      snes_write   = 1'b0;
      snes_data_in = d;
    end else begin
      snes_read = 1'b0;
    end
    repeat (12) @(negedge clk2);
    if (!wr) post_event(k_read, a, 8'h00); // Sampled while /RD still low
    else @(negedge clk2);
    snes_read  = 1'b1;
    snes_write = 1'b1;
    repeat (3) @(negedge clk2);
    if (wr) post_event(k_write, a, d);
  endtask

  task automatic mcu_access(input logic wr, input cart_pkg::snes_addr_t a,
                            input cart_pkg::snes_byte_t d);
    int n;
    n = 0;
    while (!mcu_rdy && n < mcu_limit) begin
      @(negedge clk2);
      n++;
    end
    mcu_addr  = a;
    mcu_wdata = d;
    if (wr) mcu_wrq = 1'b1;
    else mcu_rrq = 1'b1;
    @(negedge clk2);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    n = 0;
    while (!mcu_rdy && n < mcu_limit) begin
      @(negedge clk2);
      n++;
    end
    if (!mcu_rdy) begin
      handshake_errs++;
      $display("MCU %s of %h at %0t never completed", wr ? "write" : "read", a, $time);
    end
  endtask

  ////////////////////
  // Test sequence
  initial begin : stimulus
    cart_pkg::snes_addr_t a;
    cart_pkg::snes_addr_t sr [4];
    cart_pkg::snes_byte_t d;
    seed = 32'hc63f24ae;
    sr = '{24'h700010, 24'h7D0123, 24'h711FFF, 24'h7C0A55};
    handshake_errs = 0;
    for (int i = 0; i < 131072; i++) psram[i] = fill_byte(i[16:0]);
    rst_n = 1'b0;
    snes_addr_in = '0;
    snes_read = 1'b1;
    snes_write = 1'b1;
    snes_cpu_clk = 1'b0;
    snes_data_in = '0;
    mcu_addr = '0;
    mcu_wdata = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    rom_mask = 24'h00FFFF;
    saveram_mask = 24'h001FFF;
    ev_valid = 1'b0;
    ev_kind = k_reset;
    ev_addr = '0;
    ev_data = '0;
    repeat (2) @(negedge clk2);
    rst_n = 1'b1;
    @(negedge clk2);
    post_event(k_reset, 24'h0, 8'h00);

    for (int i = 0; i < 8; i++) begin // ROM reads
      a = $random(seed);
      a[15] = 1'b1;
      console_cycle(a, 1'b0, 8'h00);
    end
    foreach (sr[i]) begin
      d = $random(seed);
      console_cycle(sr[i], 1'b1, d);
      console_cycle(sr[i], 1'b0, 8'h00);
    end
    console_cycle(24'h00C000, 1'b1, 8'hA5); // ROM is read-only
    console_cycle(24'h00C000, 1'b0, 8'h00);
    console_cycle(24'h85F001, 1'b1, 8'h3C);
    console_cycle(24'h85F001, 1'b0, 8'h00);

    for (int i = 0; i < 12; i++) begin // Command window
      a = (i % 2 == 0) ? 24'h002A00 : 24'h802A00;
      a[3:0] = $random(seed);
      d = $random(seed);
      console_cycle(a, 1'b1, d);
    end
    for (int i = 0; i < 16; i++) console_cycle(24'h002A00 | 24'(i), 1'b0, 8'h00);

    // Console clock stopped
    snes_cpu_clk = 1'b0;
    repeat (int'(dead_cycles) + 16) @(negedge clk2);
    d = $random(seed);
    mcu_access(1'b1, 24'hE00155, d);
    post_event(k_mcu_wr, 24'hE00155, d);
    mcu_access(1'b0, 24'hE00155, 8'h00);
    post_event(k_mcu_rd, 24'hE00155, 8'h00);

    d = $random(seed);
    fork
      begin
        for (int i = 0; i < 6; i++) begin
          a = $random(seed);
          a[15] = 1'b1;
          console_cycle(a, 1'b0, 8'h00);
        end
      end
      begin
        repeat (30) @(negedge clk2);
        mcu_access(1'b1, 24'hE00200, d);
        mcu_access(1'b0, 24'hE00200, 8'h00);
      end
    join
    post_event(k_mcu_wr, 24'hE00200, d);
    post_event(k_mcu_rd, 24'hE00200, 8'h00);

    repeat (4) @(negedge clk2);
    $display("Error counts: %0d mismatch, %0d handshake", mismatch_cnt, handshake_errs);
    if (mismatch_cnt == 0 && handshake_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sd2snes_main.f
logic/cart_pkg.sv
logic/mem_pkg.sv
logic/snes_bus_sync.sv
logic/cart_map.sv
logic/snescmd_regs.sv
logic/rom_arbiter.sv
logic/psram_port.sv
logic/sd2snes_main.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: Bender.yml
package:
  name: sd2snes_main

sources:
  - logic/cart_pkg.sv
  - logic/mem_pkg.sv
  - logic/snes_bus_sync.sv
  - logic/cart_map.sv
  - logic/snescmd_regs.sv
  - logic/rom_arbiter.sv
  - logic/psram_port.sv
  - logic/sd2snes_main.sv
  - target: test
    files:
      - verif/tb_checker.sv
      - verif/tb_top.sv
